// ==== hw/cdc_bridge_config.svh ====
`ifndef CDC_BRIDGE_CONFIG_SVH
`define CDC_BRIDGE_CONFIG_SVH

`default_nettype none

// ==============================
// bridge build options
// ==============================

// number of PWM channels, 8 or 4
`define CDC_PWM_CH 8

// clock cycles per half SCLK period
`define CDC_SPI_DIV 4

// first byte of every host frame
`define CDC_SYNC_BYTE 8'hA5

`default_nettype wire

`endif

// ==== hw/cdc_bridge_pkg.sv ====
`default_nettype none

package cdc_bridge_pkg;

    // host command codes, second byte of a frame
    typedef enum logic [7:0] {
        OP_SET_PWM  = 8'h01,
        OP_SPI_XFER = 8'h02,
        OP_SET_LED  = 8'h03,
        OP_GET_PWM  = 8'h04
    } opcode_e;

    // one byte with a single-cycle strobe, both directions
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } byte_strobe_t;

    // ==============================
    // payload views
    // ==============================
    typedef struct packed {
        logic [7:0] channel;
        logic [7:0] duty;
    } pwm_view_t;

    typedef struct packed {
        logic [7:0] flags;
        logic [7:0] tx_byte;
    } spi_view_t;

    // last two frame bytes, read per opcode
    typedef union packed {
        pwm_view_t pwm;
        spi_view_t spi;
    } cmd_payload_u;

    typedef struct packed {
        logic       we;
        logic [7:0] channel;
        logic [7:0] duty;
    } pwm_wr_t;

    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire

// ==== hw/cmd_parser.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module cmd_parser import cdc_bridge_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  byte_strobe_t usb_rx_i,
    input  logic         spi_busy_i,
    input  logic         spi_done_i,
    input  logic [7:0]   spi_rx_i,
    input  logic [7:0]   duty_rd_i,
    output byte_strobe_t usb_tx_o,
    output pwm_wr_t      pwm_wr_o,
    output logic [7:0]   duty_rd_ch_o,
    output logic         spi_start_o,
    output logic [7:0]   spi_tx_o,
    output logic [3:0]   led_o
);

    // position of the next byte: 0 sync, 1 opcode, 2 payload high, 3 payload low
    logic [1:0]   pos_q;
    opcode_e      opcode_q;
    logic [7:0]   pay_hi_q;
    logic         frame_led_q;
    logic         err_q;
    logic [1:0]   led_hi_q;
    logic [7:0]   tx_data_q;
    logic         tx_valid_q;

    logic         take;
    logic         drop;
    logic         last;
    cmd_payload_u payload;
    logic         ch_ok;
    logic         wr_en;
    logic         get_en;
    logic         led_en;
    logic         start_en;
    logic         bad_cmd;
    logic         exec_ok;

    // bytes during an SPI transfer are lost
    assign take = usb_rx_i.valid && !spi_busy_i;
    assign drop = usb_rx_i.valid && spi_busy_i;
    assign last = take && (pos_q == 2'd3);

    // low payload byte is used straight off the bus
    assign payload = cmd_payload_u'({pay_hi_q, usb_rx_i.data});
    assign ch_ok   = payload.pwm.channel < 8'(`CDC_PWM_CH);

    // ==============================
    // opcode decode on the 4th byte
    // ==============================
    always_comb begin
        wr_en    = 1'b0;
        get_en   = 1'b0;
        led_en   = 1'b0;
        start_en = 1'b0;
        bad_cmd  = 1'b0;
        if (last) begin
            case (opcode_q)
                OP_SET_PWM: begin
                    wr_en   = ch_ok;
                    bad_cmd = !ch_ok;
                end
                OP_GET_PWM: begin
                    get_en  = ch_ok;
                    bad_cmd = !ch_ok;
                end
                OP_SET_LED:  led_en   = 1'b1;
                OP_SPI_XFER: start_en = 1'b1;
                default:     bad_cmd  = 1'b1;
            endcase
        end
    end

    assign exec_ok = last && !bad_cmd;

    // frame assembly, resync on anything but SYNC
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pos_q <= 2'd0;
        end else if (drop) begin
            pos_q <= 2'd0;
        end else if (take) begin
            case (pos_q)
                2'd0:    pos_q <= (usb_rx_i.data == `CDC_SYNC_BYTE) ? 2'd1 : 2'd0;
                2'd1:    pos_q <= 2'd2;
                2'd2:    pos_q <= 2'd3;
                default: pos_q <= 2'd0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && pos_q == 2'd1) begin
            opcode_q <= opcode_e'(usb_rx_i.data);
        end
        if (take && pos_q == 2'd2) begin
            pay_hi_q <= usb_rx_i.data;
        end
    end

    // LED and sticky error state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            frame_led_q <= 1'b0;
            err_q       <= 1'b0;
            led_hi_q    <= 2'b00;
        end else begin
            if (exec_ok) begin
                frame_led_q <= ~frame_led_q;
            end
            if (bad_cmd || drop) begin
                err_q <= 1'b1;
            end
            if (led_en) begin
                led_hi_q <= payload.pwm.duty[1:0];
            end
        end
    end

    // ==============================
    // upload byte
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= get_en || spi_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (get_en) begin
            tx_data_q <= duty_rd_i;
        end else if (spi_done_i) begin
            tx_data_q <= spi_rx_i;
        end
    end

    assign usb_tx_o     = '{data: tx_data_q, valid: tx_valid_q};
    assign pwm_wr_o     = '{we: wr_en, channel: payload.pwm.channel, duty: payload.pwm.duty};
    assign duty_rd_ch_o = payload.pwm.channel;
    assign spi_start_o  = start_en;
    assign spi_tx_o     = payload.spi.tx_byte;
    assign led_o        = {led_hi_q, err_q, frame_led_q};

endmodule

`default_nettype wire

// ==== hw/pwm_bank.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module pwm_bank import cdc_bridge_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  pwm_wr_t                pwm_wr_i,
    input  logic [7:0]             rd_ch_i,
    output logic [7:0]             rd_duty_o,
    output logic [`CDC_PWM_CH-1:0] pwm_o
);

    logic [7:0]             duty_q [`CDC_PWM_CH];
    logic [7:0]             cnt_q;
    logic [`CDC_PWM_CH-1:0] pwm_q;

    // ==============================
    // duty registers
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                duty_q[i] <= 8'h00;
            end
        end else if (pwm_wr_i.we) begin
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                if (pwm_wr_i.channel == 8'(i)) begin
                    duty_q[i] <= pwm_wr_i.duty;
                end
            end
        end
    end

    // read-back, unknown channels read as zero
    always_comb begin
        rd_duty_o = 8'h00;
        for (int i = 0; i < `CDC_PWM_CH; i++) begin
            if (rd_ch_i == 8'(i)) begin
                rd_duty_o = duty_q[i];
            end
        end
    end

    // shared counter, 255 cycle period so 255 means always on
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= 8'h00;
        end else begin
            cnt_q <= (cnt_q == 8'd254) ? 8'h00 : cnt_q + 8'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pwm_q <= '0;
        end else begin
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                pwm_q[i] <= cnt_q < duty_q[i];
            end
        end
    end

    assign pwm_o = pwm_q;

endmodule

`default_nettype wire

// ==== hw/spi_master.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module spi_master import cdc_bridge_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  logic [7:0] tx_i,
    input  logic       miso_i,
    output spi_pins_t  spi_o,
    output logic       busy_o,
    output logic       done_o,
    output logic [7:0] rx_o
);

    localparam int unsigned DIV_W = (`CDC_SPI_DIV > 1) ? $clog2(`CDC_SPI_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CDC_SPI_DIV - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_TRAIL
    } state_e;

    state_e           state_q;
    logic [DIV_W-1:0] div_q;
    logic [2:0]       bit_q;
    logic [7:0]       tx_sr_q;
    logic [7:0]       rx_sr_q;
    logic             sclk_q;
    logic             cs_n_q;
    logic             mosi_q;
    logic             done_q;
    logic             half_tick;

    assign half_tick = (div_q == DIV_LAST);

    // ==============================
    // transfer FSM
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            div_q   <= '0;
            bit_q   <= 3'd0;
            sclk_q  <= 1'b0;
            cs_n_q  <= 1'b1;
            mosi_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_SHIFT;
                        cs_n_q  <= 1'b0;
                        mosi_q  <= tx_i[7];
                        div_q   <= '0;
                        bit_q   <= 3'd0;
                    end
                end
                S_SHIFT: begin
                    if (half_tick) begin
                        div_q  <= '0;
                        sclk_q <= ~sclk_q;
                        // falling edge: next bit out, or stop after bit 7
                        if (sclk_q) begin
                            if (bit_q == 3'd7) begin
                                state_q <= S_TRAIL;
                            end else begin
                                bit_q  <= bit_q + 3'd1;
                                mosi_q <= tx_sr_q[7];
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                S_TRAIL: begin
                    if (half_tick) begin
                        state_q <= S_IDLE;
                        cs_n_q  <= 1'b1;
                        mosi_q  <= 1'b0;
                        done_q  <= 1'b1;
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // shift registers, rx is held after done
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && start_i) begin
            tx_sr_q <= {tx_i[6:0], 1'b0};
        end else if (state_q == S_SHIFT && half_tick && sclk_q) begin
            tx_sr_q <= {tx_sr_q[6:0], 1'b0};
        end
        if (state_q == S_SHIFT && half_tick && !sclk_q) begin
            rx_sr_q <= {rx_sr_q[6:0], miso_i};
        end
    end

    assign spi_o  = '{sclk: sclk_q, cs_n: cs_n_q, mosi: mosi_q};
    assign busy_o = (state_q != S_IDLE);
    assign done_o = done_q;
    assign rx_o   = rx_sr_q;

endmodule

`default_nettype wire

// ==== hw/cdc_bridge_top.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module cdc_bridge_top import cdc_bridge_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  byte_strobe_t           usb_rx_i,
    input  logic                   spi_miso_i,
    output byte_strobe_t           usb_tx_o,
    output logic [`CDC_PWM_CH-1:0] pwm_o,
    output spi_pins_t              spi_o,
    output logic [3:0]             led_o
);

    // parser to PWM bank
    pwm_wr_t    pwm_wr;
    logic [7:0] duty_rd_ch;
    logic [7:0] duty_rd;

    // parser to SPI master
    logic       spi_start;
    logic [7:0] spi_tx;
    logic       spi_busy;
    logic       spi_done;
    logic [7:0] spi_rx;

    // ==============================
    // command path
    // ==============================
    cmd_parser cmd_parser_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .usb_rx_i     (usb_rx_i),
        .spi_busy_i   (spi_busy),
        .spi_done_i   (spi_done),
        .spi_rx_i     (spi_rx),
        .duty_rd_i    (duty_rd),
        .usb_tx_o     (usb_tx_o),
        .pwm_wr_o     (pwm_wr),
        .duty_rd_ch_o (duty_rd_ch),
        .spi_start_o  (spi_start),
        .spi_tx_o     (spi_tx),
        .led_o        (led_o)
    );

    pwm_bank pwm_bank_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .pwm_wr_i  (pwm_wr),
        .rd_ch_i   (duty_rd_ch),
        .rd_duty_o (duty_rd),
        .pwm_o     (pwm_o)
    );

    spi_master spi_master_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (spi_start),
        .tx_i    (spi_tx),
        .miso_i  (spi_miso_i),
        .spi_o   (spi_o),
        .busy_o  (spi_busy),
        .done_o  (spi_done),
        .rx_o    (spi_rx)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD_NS = 20
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk_o = 1'b0;

    always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== test/cdc_bridge_properties.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module cdc_bridge_properties import cdc_bridge_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input byte_strobe_t           usb_tx_i,
    input spi_pins_t              spi_i,
    input logic [`CDC_PWM_CH-1:0] pwm_i,
    input pwm_wr_t                pwm_wr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // shadow of which channels hold a zero duty
    logic [`CDC_PWM_CH-1:0] zero_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            zero_q <= '1;
        end else if (pwm_wr_i.we) begin
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                if (pwm_wr_i.channel == 8'(i)) begin
                    zero_q[i] <= (pwm_wr_i.duty == 8'h00);
                end
            end
        end
    end

    // ==============================
    // interface rules
    // ==============================
    upload_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        usb_tx_i.valid |=> !usb_tx_i.valid)
        else $error("upload valid held for two cycles");

    sclk_idle_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        spi_i.cs_n |-> !spi_i.sclk)
        else $error("sclk high while chip select is inactive");

    // pin lags the duty register by one cycle
    zero_duty_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pwm_i & zero_q & $past(zero_q)) == '0)
        else $error("pwm pin high with a zero duty");

endmodule

bind cdc_bridge_top cdc_bridge_properties cdc_bridge_properties_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .usb_tx_i (usb_tx_o),
    .spi_i    (spi_o),
    .pwm_i    (pwm_o),
    .pwm_wr_i (pwm_wr)
);

`default_nettype wire

// ==== test/cdc_bridge_tb.sv ====
`include "cdc_bridge_config.svh"
`default_nettype none

module cdc_bridge_tb import cdc_bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CH            = `CDC_PWM_CH;
    localparam int REPLY_TIMEOUT = 200;
    localparam logic [7:0] GARBAGE [3] = '{8'h00, 8'h5A, 8'hFF};

    // one frame with its expected result
    typedef struct packed {
        logic [1:0] pre;
        logic [7:0] sync;
        logic [7:0] op;
        logic [7:0] hi;
        logic [7:0] lo;
        logic [7:0] miso;
        logic       reply;
        logic [7:0] exp;
        logic       exec;
    } row_t;

    logic          clk;
    logic          rst_n;
    byte_strobe_t  usb_rx;
    logic          spi_miso;
    byte_strobe_t  usb_tx;
    logic [CH-1:0] pwm;
    spi_pins_t     spi;
    logic [3:0]    led;

    logic          spi_sclk;
    logic          spi_cs_n;
    logic          spi_mosi;
    logic [7:0]    slave_tx;
    logic [7:0]    slave_sr;
    logic [7:0]    slave_rx;

    row_t          rows[$];
    logic [7:0]    duty [CH];
    int            high_cnt [CH];
    integer        seed;
    logic          led0_exp;
    logic          err_exp;
    logic [1:0]    led_hi_exp;
    logic [7:0]    got;
    int            reply_lat;

    tb_clock_gen clk_gen_i (.clk_o(clk));

    cdc_bridge_top cdc_bridge_top_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .usb_rx_i   (usb_rx),
        .spi_miso_i (spi_miso),
        .usb_tx_o   (usb_tx),
        .pwm_o      (pwm),
        .spi_o      (spi),
        .led_o      (led)
    );

    assign spi_sclk = spi.sclk;
    assign spi_cs_n = spi.cs_n;
    assign spi_mosi = spi.mosi;

    // ==============================
    // SPI slave model, mode 0
    // ==============================
    always @(negedge spi_cs_n) begin
        #2;
        slave_sr = slave_tx;
        spi_miso = slave_sr[7];
    end

    always @(posedge spi_sclk) begin
        slave_rx = {slave_rx[6:0], spi_mosi};
    end

    always @(negedge spi_sclk) begin
        #2;
        slave_sr = {slave_sr[6:0], 1'b0};
        spi_miso = slave_sr[7];
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("[FAIL] %s exp=%0h got=%0h", name, exp, got);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // inputs change 2 ns after the edge, outputs are settled there too
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b);
        usb_rx = '{data: b, valid: 1'b1};
        tick();
        usb_rx.valid = 1'b0;
    endtask

    // cycles counts the clocks waited after the last frame byte
    task automatic wait_reply(output logic [7:0] data, output int cycles);
        int n;
        n = 0;
        while (!usb_tx.valid && n < REPLY_TIMEOUT) begin
            tick();
            n++;
        end
        cycles = n;
        if (!usb_tx.valid) begin
            $display("timed out waiting for an upload byte");
            $display("TESTS FAILED");
            $fatal(1, "no upload byte");
        end else begin
            data = usb_tx.data;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check("usb_tx.valid", 0, usb_tx.valid);
            tick();
        end
    endtask

    task automatic add_row(input logic [1:0] pre, input logic [7:0] op, input logic [7:0] hi,
                           input logic [7:0] lo, input logic [7:0] miso, input logic reply,
                           input logic [7:0] exp, input logic exec);
        rows.push_back(row_t'{pre, `CDC_SYNC_BYTE, op, hi, lo, miso, reply, exp, exec});
    endtask

    initial begin
        rst_n    = 1'b0;
        usb_rx   = '0;
        spi_miso = 1'b0;
        slave_tx = 8'h00;
        slave_sr = 8'h00;
        slave_rx = 8'h00;
        seed     = 32'h3420_3124;

        // ==============================
        // stimulus table
        // ==============================
        for (int i = 0; i < CH; i++) begin
            duty[i] = 8'($random(seed));
        end
        duty[CH-1] = 8'hFF;
        duty[CH-2] = 8'h00;
        for (int i = 0; i < CH; i++) begin
            add_row(0, OP_SET_PWM, 8'(i), duty[i], 8'h00, 1'b0, 8'h00, 1'b1);
        end
        for (int i = 0; i < CH; i++) begin
            add_row(0, OP_GET_PWM, 8'(i), 8'h00, 8'h00, 1'b1, duty[i], 1'b1);
        end
        add_row(0, OP_SPI_XFER, 8'h00, 8'h3C, 8'hC5, 1'b1, 8'hC5, 1'b1);
        add_row(0, OP_SPI_XFER, 8'h00, 8'hA1, 8'h5E, 1'b1, 8'h5E, 1'b1);
        add_row(3, OP_SET_LED, 8'h00, 8'hF6, 8'h00, 1'b0, 8'h00, 1'b1);
        add_row(2, OP_GET_PWM, 8'h00, 8'h00, 8'h00, 1'b1, duty[0], 1'b1);
        add_row(0, 8'h7E, 8'h00, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0);
        add_row(0, OP_SET_PWM, 8'(CH), 8'h55, 8'h00, 1'b0, 8'h00, 1'b0);
        add_row(0, OP_GET_PWM, 8'h00, 8'h00, 8'h00, 1'b1, duty[0], 1'b1);
        add_row(0, OP_GET_PWM, 8'(CH-1), 8'h00, 8'h00, 1'b1, duty[CH-1], 1'b1);
        add_row(1, OP_SET_LED, 8'h00, 8'h01, 8'h00, 1'b0, 8'h00, 1'b1);
        add_row(0, OP_SPI_XFER, 8'h00, 8'h96, 8'h0F, 1'b1, 8'h0F, 1'b1);

        repeat (8) tick();
        rst_n = 1'b1;
        tick();

        // idle state after reset
        check("pwm_o", 0, pwm);
        check("spi_o.cs_n", 1, spi.cs_n);
        check("spi_o.sclk", 0, spi.sclk);
        check("led_o", 0, led);
        expect_quiet(2);

        led0_exp   = 1'b0;
        err_exp    = 1'b0;
        led_hi_exp = 2'b00;

        foreach (rows[r]) begin
            slave_tx = rows[r].miso;
            slave_rx = 8'h00;
            for (int g = 0; g < rows[r].pre; g++) begin
                send_byte(GARBAGE[g]);
            end
            send_byte(rows[r].sync);
            send_byte(rows[r].op);
            send_byte(rows[r].hi);
            send_byte(rows[r].lo);
            if (rows[r].reply) begin
                wait_reply(got, reply_lat);
                check("usb_tx.data", rows[r].exp, got);
                // read-back is due in the cycle right after the last byte
                if (rows[r].op == OP_GET_PWM) begin
                    check("usb_tx.valid latency", 0, reply_lat);
                end
                if (rows[r].op == OP_SPI_XFER) begin
                    check("spi mosi byte", rows[r].lo, slave_rx);
                end
            end else begin
                expect_quiet(4);
            end
            if (rows[r].exec) begin
                led0_exp = ~led0_exp;
            end else begin
                err_exp = 1'b1;
            end
            if (rows[r].exec && rows[r].op == OP_SET_LED) begin
                led_hi_exp = rows[r].lo[1:0];
            end
            check("led_o", {led_hi_exp, err_exp, led0_exp}, led);
        end

        // ==============================
        // one full PWM period
        // ==============================
        for (int i = 0; i < CH; i++) begin
            high_cnt[i] = 0;
        end
        for (int c = 0; c < 255; c++) begin
            for (int i = 0; i < CH; i++) begin
                if (pwm[i]) begin
                    high_cnt[i]++;
                end
            end
            tick();
        end
        for (int i = 0; i < CH; i++) begin
            check($sformatf("pwm_o[%0d] high cycles", i), duty[i], high_cnt[i]);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/cdc_bridge_pkg.sv
hw/cmd_parser.sv
hw/pwm_bank.sv
hw/spi_master.sv
hw/cdc_bridge_top.sv
test/tb_clock_gen.sv
test/cdc_bridge_properties.sv
test/cdc_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cdc_bridge_tb
RTL_TOP   ?= cdc_bridge_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
RTL_SRCS  ?= hw/cdc_bridge_pkg.sv hw/cmd_parser.sv hw/pwm_bank.sv \
             hw/spi_master.sv hw/cdc_bridge_top.sv
LINT_FLAGS ?= --lint-only +incdir+hw
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
